/* src.f */
hdl/wb_ram_pkg.sv
hdl/wb_ram_ifs.sv
hdl/wb_ram_req_decode.sv
hdl/line_ram.sv
hdl/burst_reader.sv
hdl/wb_line_ram_top.sv
sim/tb_clk_gen.sv
sim/tb_wb_line_ram.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then check the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert \
  --top-module tb_wb_line_ram \
  -f src.f \
  -Mdir obj_dir -o sim_tb > "${BUILD_LOG}" 2>&1
if [ $? -ne 0 ]; then
  cat "${BUILD_LOG}"
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "${SIM_LOG}" 2>&1
run_status=$?
cat "${SIM_LOG}"

if grep -q "Test failed" "${SIM_LOG}"; then
  exit 1
fi
if [ ${run_status} -ne 0 ]; then
  echo "Simulation exited with status ${run_status}"
  exit 1
fi
exit 0

/* sim/tb_wb_line_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_wb_line_ram;
  import wb_ram_pkg::*;

  localparam int unsigned RAM_LINES    = 64;
  localparam int unsigned RAM_LATENCY  = 4;
  localparam int unsigned CLK_NS       = 20;
  localparam int unsigned RST_CYCLES   = 10;
  localparam int unsigned IDX_W        = $clog2(RAM_LINES);
  localparam int unsigned RAM_BYTES    = RAM_LINES * LINE_STRB_W;
  localparam int unsigned BYTE_IDX_W   = $clog2(RAM_BYTES);
  // Accesses issued over all tests
  localparam int unsigned NUM_ACCESSES = 22;
  localparam int unsigned TIMEOUT_NS   =
    (RST_CYCLES + NUM_ACCESSES * (RAM_LATENCY + 4) + 100) * CLK_NS;

  logic              clk;
  logic              rst_n;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  logic [ADDR_W-1:0] wb_adr;
  logic [WORD_W-1:0] wb_dat_w;
  logic [SEL_W-1:0]  wb_sel;
  logic [2:0]        wb_cti;
  logic [WORD_W-1:0] wb_dat_r;
  logic              wb_ack;

  // Byte image of the whole RAM
  // Starts all zero like the DUT memory
  logic [7:0]  ref_mem [RAM_BYTES] = '{default: '0};
  logic [31:0] lfsr_q = 32'h390c;

  tb_clk_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(RST_CYCLES)) i_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  wb_line_ram_top #(
    .RAM_LINES   (RAM_LINES),
    .RAM_LATENCY (RAM_LATENCY)
  ) i_wb_line_ram_top (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_w),
    .wb_sel_i (wb_sel),
    .wb_cti_i (wb_cti),
    .wb_dat_o (wb_dat_r),
    .wb_ack_o (wb_ack)
  );

  // ==================================================
  // Helpers
  // ==================================================
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp) else begin
      abort_run($sformatf("FAILED at %0t ns: %s expected %h, got %h",
                          $time, name, exp, act));
    end
  endtask

  // Right-shift Galois LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] val;
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val    = {val[30:0], lfsr_q[0]};
    end
    return val;
  endfunction

  function automatic logic [31:0] make_adr(input logic [31:0] line, input logic [31:0] off);
    return (line << LINE_OFF_W) | (off << BYTE_OFF_W);
  endfunction

  // Index truncation is the modulo wrap of a power-of-two RAM
  task automatic model_write(input logic [31:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel);
    for (int i = 0; i < SEL_W; i++) begin
      if (sel[i]) begin
        ref_mem[{adr[BYTE_IDX_W-1:2], i[1:0]}] = dat[i*8 +: 8];
      end
    end
  endtask

  function automatic logic [31:0] model_word(input logic [31:0] adr);
    logic [31:0] w;
    for (int i = 0; i < SEL_W; i++) begin
      w[i*8 +: 8] = ref_mem[{adr[BYTE_IDX_W-1:2], i[1:0]}];
    end
    return w;
  endfunction

  // ==================================================
  // Bus cycles
  // ==================================================
  task automatic present_req(input logic we, input logic [31:0] adr,
                             input logic [31:0] dat, input logic [3:0] sel,
                             input logic [2:0] cti);
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = dat;
    wb_sel   = sel;
    wb_cti   = cti;
  endtask

  // Counts cycles from first presentation to ack
  // Sampled one step after each falling edge
  task automatic wait_ack(output int unsigned cycles);
    cycles = 0;
    #1;
    while (wb_ack !== 1'b1) begin
      @(negedge clk);
      #1;
      cycles++;
    end
  endtask

  task automatic bus_idle();
    @(negedge clk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    wb_cti = CTI_CLASSIC;
  endtask

  task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat,
                          input logic [3:0] sel);
    int unsigned cycles;
    present_req(1'b1, adr, dat, sel, CTI_CLASSIC);
    wait_ack(cycles);
    check_value("wb_ack_o write latency", 32'd0, cycles);
    @(posedge clk);
    model_write(adr, dat, sel);
  endtask

  task automatic wb_read(input logic [31:0] adr, input logic [2:0] cti,
                         input int unsigned exp_lat);
    int unsigned cycles;
    present_req(1'b0, adr, '0, 4'hf, cti);
    wait_ack(cycles);
    check_value("wb_ack_o read latency", exp_lat, cycles);
    check_value("wb_dat_o", model_word(adr), wb_dat_r);
    @(posedge clk);
  endtask

  // ==================================================
  // Directed tests
  // ==================================================
  task automatic reset_read_latency();
    logic [31:0] adr;
    adr = rand_bits(30) << 2;
    wb_read(adr, CTI_CLASSIC, RAM_LATENCY);
    bus_idle();
  endtask

  task automatic write_read_back();
    logic [31:0] line;
    logic [31:0] off;
    line = rand_bits(IDX_W);
    off  = rand_bits(OFFSET_W);
    wb_write(make_adr(line, off), rand_bits(32), 4'hf);
    wb_read(make_adr(line, off), CTI_CLASSIC, RAM_LATENCY);
    // Neighbours in the line must be untouched
    for (int unsigned o = 1; o < WORDS_PER_LINE; o++) begin
      wb_read(make_adr(line, (off + o) % WORDS_PER_LINE), CTI_CLASSIC, RAM_LATENCY);
    end
    bus_idle();
  endtask

  task automatic byte_lane_merge();
    logic [31:0] adr;
    adr = make_adr(rand_bits(IDX_W), rand_bits(OFFSET_W));
    wb_write(adr, rand_bits(32), 4'b0001);
    wb_write(adr, rand_bits(32), 4'b0110);
    wb_write(adr, rand_bits(32), 4'b1000);
    wb_write(adr, rand_bits(32), 4'b1011);
    wb_read(adr, CTI_CLASSIC, RAM_LATENCY);
    bus_idle();
  endtask

  task automatic incr_burst_read();
    logic [31:0] line;
    line = rand_bits(IDX_W);
    for (int unsigned o = 0; o < WORDS_PER_LINE; o++) begin
      wb_write(make_adr(line, o), rand_bits(32), 4'hf);
    end
    // Only the first beat waits for the RAM
    wb_read(make_adr(line, 0), CTI_INCR, RAM_LATENCY);
    wb_read(make_adr(line, 1), CTI_INCR, 0);
    wb_read(make_adr(line, 2), CTI_INCR, 0);
    wb_read(make_adr(line, 3), CTI_EOB, 0);
    // Back in idle so the full latency applies again
    wb_read(make_adr(rand_bits(IDX_W), rand_bits(OFFSET_W)), CTI_CLASSIC, RAM_LATENCY);
    bus_idle();
  endtask

  task automatic address_wrap();
    logic [31:0] k;
    logic [31:0] off;
    logic [31:0] dat;
    int unsigned cycles;
    k   = rand_bits(IDX_W);
    off = rand_bits(OFFSET_W);
    dat = rand_bits(32);
    wb_write(make_adr(RAM_LINES + k, off), dat, 4'hf);
    // Line RAM_LINES + k lands on line k
    present_req(1'b0, make_adr(k, off), '0, 4'hf, CTI_CLASSIC);
    wait_ack(cycles);
    check_value("wb_ack_o read latency", RAM_LATENCY, cycles);
    check_value("wb_dat_o wrapped", dat, wb_dat_r);
    @(posedge clk);
    bus_idle();
  endtask

  // ==================================================
  // Sequence and watchdog
  // ==================================================
  initial begin : watchdog
    #(TIMEOUT_NS);
    abort_run("Watchdog expired before all tests finished, the run timed out");
  end

  initial begin : main
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    wb_sel   = '0;
    wb_cti   = CTI_CLASSIC;
    @(posedge rst_n);
    reset_read_latency();
    write_read_back();
    byte_lane_merge();
    incr_burst_read();
    address_wrap();
    @(posedge clk);
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* sim/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS    = 20,
  parameter int unsigned RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_no
);

  // Free-running clock
  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk_o = ~clk_o;
    end
  end

  // Reset low for a fixed number of cycles, released on a falling edge
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

/* hdl/wb_line_ram_top.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_line_ram_top #(
  parameter int unsigned RAM_LINES   = 64,
  parameter int unsigned RAM_LATENCY = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  // Wishbone B4 slave, no stall, err or rty
  input  logic                          wb_cyc_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_we_i,
  input  logic [wb_ram_pkg::ADDR_W-1:0] wb_adr_i,
  input  logic [wb_ram_pkg::WORD_W-1:0] wb_dat_i,
  input  logic [wb_ram_pkg::SEL_W-1:0]  wb_sel_i,
  input  logic [2:0]                    wb_cti_i,
  output logic [wb_ram_pkg::WORD_W-1:0] wb_dat_o,
  output logic                          wb_ack_o
);
  import wb_ram_pkg::*;

  // Internal bundles
  line_wr_if #(.RAM_LINES(RAM_LINES)) i_line_wr_if ();
  beat_if i_beat_if ();

  // Read launch and return between reader and RAM
  logic              rd_launch;
  logic [LINE_W-1:0] rd_line;
  logic              rd_valid;

  // ===============================================
  // Request decoder
  // ===============================================
  wb_ram_req_decode #(
    .RAM_LINES (RAM_LINES)
  ) i_req_decode (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .cyc_i     (wb_cyc_i),
    .stb_i     (wb_stb_i),
    .we_i      (wb_we_i),
    .adr_i     (wb_adr_i),
    .dat_i     (wb_dat_i),
    .sel_i     (wb_sel_i),
    .cti_i     (wb_cti_i),
    .wr_port   (i_line_wr_if),
    .beat_port (i_beat_if)
  );

  // ===============================================
  // Line RAM
  // ===============================================
  line_ram #(
    .RAM_LINES   (RAM_LINES),
    .RAM_LATENCY (RAM_LATENCY)
  ) i_line_ram (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .wr_port     (i_line_wr_if),
    .rd_launch_i (rd_launch),
    // Reads use the decoded line index of the current request
    .rd_addr_i   (i_line_wr_if.line_addr),
    .rd_line_o   (rd_line),
    .rd_valid_o  (rd_valid)
  );

  // ===============================================
  // Burst reader
  // ===============================================
  burst_reader i_burst_reader (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .beat_port   (i_beat_if),
    .rd_launch_o (rd_launch),
    .rd_line_i   (rd_line),
    .rd_valid_i  (rd_valid),
    .dat_o       (wb_dat_o),
    .ack_o       (wb_ack_o)
  );

endmodule

`default_nettype wire

/* hdl/burst_reader.sv */
`timescale 1ns/1ps
`default_nettype none

module burst_reader (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  beat_if.slave                         beat_port,
  output logic                          rd_launch_o,
  input  logic [wb_ram_pkg::LINE_W-1:0] rd_line_i,
  input  logic                          rd_valid_i,
  output logic [wb_ram_pkg::WORD_W-1:0] dat_o,
  output logic                          ack_o
);
  import wb_ram_pkg::*;

  burst_state_e      state_q;
  burst_state_e      state_d;
  logic [LINE_W-1:0] line_buf_q;
  logic [LINE_W-1:0] src_line;
  logic              wr_req;
  logic              rd_req;
  logic              capture;

  assign wr_req = beat_port.beat_req & beat_port.beat_we;
  assign rd_req = beat_port.beat_req & ~beat_port.beat_we;

  // ===============================================
  // FSM
  // ===============================================
  always_comb begin
    state_d     = state_q;
    rd_launch_o = 1'b0;
    ack_o       = 1'b0;
    capture     = 1'b0;
    case (state_q)
      ST_IDLE: begin
        if (wr_req) begin
          // Write lands at this edge, ack right away
          ack_o = 1'b1;
        end else if (rd_req) begin
          // One launch per access
          rd_launch_o = 1'b1;
          state_d     = ST_WAIT_LINE;
        end
      end
      ST_WAIT_LINE: begin
        // Master holds stb, so the line meets the same request
        if (rd_valid_i) begin
          capture = 1'b1;
          ack_o   = rd_req;
          if (beat_port.beat_cti == CTI_INCR) begin
            state_d = ST_BURST;
          end else begin
            state_d = ST_IDLE;
          end
        end
      end
      ST_BURST: begin
        // Later beats come from the buffer with no RAM access
        if (rd_req) begin
          ack_o = 1'b1;
          // EOB closes the burst, classic is taken as a close too
          if (beat_port.beat_cti != CTI_INCR) begin
            state_d = ST_IDLE;
          end
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ===============================================
  // Line buffer and word select
  // ===============================================

  // Hold the arriving line for the rest of a burst
  always_ff @(posedge clk_i) begin
    if (capture) begin
      line_buf_q <= rd_line_i;
    end
  end

  // Arrival beat reads the RAM output, burst beats the buffer
  assign src_line = (state_q == ST_BURST) ? line_buf_q : rd_line_i;
  assign dat_o    = src_line[beat_port.beat_offset*WORD_W +: WORD_W];

  // Writes inside a read would be lost, no ack path exists there
  a_wr_only_idle: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    wr_req |-> (state_q == ST_IDLE)
  );

  // RAM pipe returns only what this FSM is waiting for
  a_valid_when_waiting: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rd_valid_i |-> (state_q == ST_WAIT_LINE)
  );

endmodule

`default_nettype wire

/* hdl/line_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module line_ram #(
  parameter int unsigned RAM_LINES   = 64,
  parameter int unsigned RAM_LATENCY = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  line_wr_if.slave                      wr_port,
  input  logic                          rd_launch_i,
  input  logic [$clog2(RAM_LINES)-1:0]  rd_addr_i,
  output logic [wb_ram_pkg::LINE_W-1:0] rd_line_o,
  output logic                          rd_valid_o
);
  import wb_ram_pkg::*;

  // Line storage, zero at power-on
  logic [LINE_W-1:0]      mem_q [RAM_LINES] = '{default: '0};

  // Read data and its valid flag, one stage per latency cycle
  logic [LINE_W-1:0]      line_pipe_q [RAM_LATENCY];
  logic [RAM_LATENCY-1:0] valid_pipe_q;

  // ===============================================
  // Write side
  // ===============================================

  // Per-byte enables into the addressed line
  always_ff @(posedge clk_i) begin
    if (wr_port.wr_en) begin
      for (int b = 0; b < LINE_STRB_W; b++) begin
        if (wr_port.wstrb[b]) begin
          mem_q[wr_port.line_addr][b*8 +: 8] <= wr_port.wdata[b*8 +: 8];
        end
      end
    end
  end

  // ===============================================
  // Read side
  // ===============================================

  // Line is sampled at launch, then walks the pipe
  always_ff @(posedge clk_i) begin
    if (rd_launch_i) begin
      line_pipe_q[0] <= mem_q[rd_addr_i];
    end
    for (int s = 1; s < RAM_LATENCY; s++) begin
      line_pipe_q[s] <= line_pipe_q[s-1];
    end
  end

  // Valid travels alongside, several launches may be in flight
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      valid_pipe_q <= '0;
    end else begin
      valid_pipe_q <= {valid_pipe_q[RAM_LATENCY-2:0], rd_launch_i};
    end
  end

  // Launch in cycle 0, arrival in cycle RAM_LATENCY
  assign rd_line_o  = line_pipe_q[RAM_LATENCY-1];
  assign rd_valid_o = valid_pipe_q[RAM_LATENCY-1];

  // Reader launches only from idle, where writes are served
  a_no_wr_with_launch: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(wr_port.wr_en && rd_launch_i)
  );

  // Wrap by index truncation needs a power-of-two depth
  a_lines_pow2: assert property (
    @(posedge clk_i)
    (RAM_LINES & (RAM_LINES - 1)) == 0
  );

endmodule

`default_nettype wire

/* hdl/wb_ram_req_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_ram_req_decode #(
  parameter int unsigned RAM_LINES = 64
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          cyc_i,
  input  logic                          stb_i,
  input  logic                          we_i,
  input  logic [wb_ram_pkg::ADDR_W-1:0] adr_i,
  input  logic [wb_ram_pkg::WORD_W-1:0] dat_i,
  input  logic [wb_ram_pkg::SEL_W-1:0]  sel_i,
  input  logic [2:0]                    cti_i,
  line_wr_if.master                     wr_port,
  beat_if.master                        beat_port
);
  import wb_ram_pkg::*;

  localparam int unsigned IDX_W = $clog2(RAM_LINES);

  logic                   req;
  logic                   wr_req;
  logic [OFFSET_W-1:0]    offset;
  logic [IDX_W-1:0]       line_idx;
  cti_e                   cti;
  logic [LINE_STRB_W-1:0] wstrb;

  // Request present while cyc and stb are high
  assign req    = cyc_i & stb_i;
  assign wr_req = req & we_i;

  // Address split
  assign offset   = adr_i[BYTE_OFF_W +: OFFSET_W];
  // Bits above the index are dropped, so addresses wrap by RAM size
  assign line_idx = adr_i[LINE_OFF_W +: IDX_W];

  // Cycle type decode
  always_comb begin
    case (cti_i)
      CTI_INCR: cti = CTI_INCR;
      CTI_EOB:  cti = CTI_EOB;
      // Constant address and reserved codes act as classic
      default:  cti = CTI_CLASSIC;
    endcase
  end

  // Byte lanes of the addressed word only
  always_comb begin
    wstrb = '0;
    if (wr_req) begin
      wstrb[offset*SEL_W +: SEL_W] = sel_i;
    end
  end

  // ===============================================
  // Line write port
  // ===============================================
  assign wr_port.wr_en     = wr_req;
  assign wr_port.line_addr = line_idx;
  // Same word in every slot, strobes pick the one that lands
  assign wr_port.wdata     = {WORDS_PER_LINE{dat_i}};
  assign wr_port.wstrb     = wstrb;

  // ===============================================
  // Beat descriptor
  // ===============================================
  assign beat_port.beat_req    = req;
  assign beat_port.beat_we     = we_i;
  assign beat_port.beat_cti    = cti;
  assign beat_port.beat_offset = offset;

  // Empty sel would ack a write that stores nothing
  a_wr_sel_nonzero: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    wr_req |-> (sel_i != '0)
  );

endmodule

`default_nettype wire

/* hdl/wb_ram_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

// ===============================================
// Line write port, decoder to line RAM
// ===============================================
interface line_wr_if #(
  parameter int unsigned RAM_LINES = 64
);
  import wb_ram_pkg::*;

  localparam int unsigned IDX_W = $clog2(RAM_LINES);

  // High for one cycle per acked write
  logic                   wr_en;
  // Line index, also used as the read launch address
  logic [IDX_W-1:0]       line_addr;
  // Write word copied into every word slot
  logic [LINE_W-1:0]      wdata;
  // Byte enables, only the addressed word's lanes set
  logic [LINE_STRB_W-1:0] wstrb;

  modport master (
    output wr_en, line_addr, wdata, wstrb
  );

  modport slave (
    input wr_en, line_addr, wdata, wstrb
  );

endinterface

// ===============================================
// Beat descriptor, decoder to burst reader
// ===============================================
interface beat_if;
  import wb_ram_pkg::*;

  // cyc and stb both high
  logic                beat_req;
  logic                beat_we;
  // Classified cycle type
  cti_e                beat_cti;
  // Word within the line
  logic [OFFSET_W-1:0] beat_offset;

  modport master (
    output beat_req, beat_we, beat_cti, beat_offset
  );

  modport slave (
    input beat_req, beat_we, beat_cti, beat_offset
  );

endinterface

`default_nettype wire

/* hdl/wb_ram_pkg.sv */
`default_nettype none

package wb_ram_pkg;

  // ===============================================
  // Bus and line geometry
  // ===============================================

  // Wishbone data path
  localparam int unsigned WORD_W = 32;
  localparam int unsigned SEL_W  = WORD_W / 8;
  localparam int unsigned ADDR_W = 32;

  // One RAM line is one cache line
  localparam int unsigned LINE_W         = 128;
  localparam int unsigned WORDS_PER_LINE = LINE_W / WORD_W;
  localparam int unsigned LINE_STRB_W    = LINE_W / 8;

  // Byte address split: byte in word, then word in line
  localparam int unsigned BYTE_OFF_W = $clog2(SEL_W);
  localparam int unsigned OFFSET_W   = $clog2(WORDS_PER_LINE);
  // First address bit of the line index
  localparam int unsigned LINE_OFF_W = BYTE_OFF_W + OFFSET_W;

  // ===============================================
  // Encodings
  // ===============================================

  // Wishbone B4 cycle type identifier
  typedef enum logic [2:0] {
    CTI_CLASSIC = 3'b000,
    CTI_INCR    = 3'b010,
    CTI_EOB     = 3'b111
  } cti_e;

  // Burst reader FSM
  typedef enum logic [1:0] {
    ST_IDLE      = 2'b00,
    ST_WAIT_LINE = 2'b01,
    ST_BURST     = 2'b10
  } burst_state_e;

endpackage

`default_nettype wire
